//--- common/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // start bit, eight data bits, odd parity and stop bit.
  localparam int FRAME_BITS = 11;

  // meaning of a host command word.
  typedef struct packed {
    logic       wr;    // 1 for a write, 0 for a read.
    logic [6:0] addr;
    logic [7:0] wdata;
  } cmd_fields_t;

  // the same word as it goes out on the line, high byte first.
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } cmd_bytes_t;

  typedef union packed {
    cmd_fields_t fields;
    cmd_bytes_t  bytes;
  } cmd_word_u;

  // reply to a read command.
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err; // bad parity or a low stop bit.
    logic       timeout;    // no start bit inside the reply window.
  } rd_resp_t;

  // what the shared down-counter is timing.
  typedef enum logic [1:0] {
    TM_BIT,  // one bit period, reloads on its own.
    TM_GAP,  // pause between the two command frames.
    TM_WAIT  // window in which the reply has to start.
  } timer_mode_e;

endpackage

//--- src/baud_timer.sv
`timescale 1ns/1ps

module baud_timer
  import uart_cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434,
  parameter int GAP_CYCLES   = 100,
  parameter int RESP_TIMEOUT = 4096
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  timer_mode_e mode,
  output logic        bit_tick,
  output logic        done
);

  localparam int MAX_GB = (GAP_CYCLES > CLKS_PER_BIT) ? GAP_CYCLES : CLKS_PER_BIT;
  localparam int MAX_LOAD = (RESP_TIMEOUT > MAX_GB) ? RESP_TIMEOUT : MAX_GB;
  localparam int CW = $clog2(MAX_LOAD + 1);

  logic [CW-1:0] cnt;
  logic [CW-1:0] load;
  timer_mode_e   mode_q;
  logic          run;
  logic          at_end;

  // the gap loses three cycles to the done and start strobes around it.
  always_comb
  begin
    case (mode)
      TM_BIT:  load = CW'(CLKS_PER_BIT - 1);
      TM_GAP:  load = CW'(GAP_CYCLES - 3);
      default: load = CW'(RESP_TIMEOUT - 1);
    endcase
  end

  assign at_end   = run & (cnt == '0);
  assign bit_tick = at_end & (mode_q == TM_BIT);
  assign done     = at_end & (mode_q != TM_BIT);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt    <= '0;
      mode_q <= TM_BIT;
      run    <= 1'b0;
    end
    else if (start)
    begin
      cnt    <= load;
      mode_q <= mode;
      run    <= 1'b1;
    end
    else if (run)
    begin
      if (cnt != '0)
        cnt <= cnt - 1'b1;
      else if (mode_q == TM_BIT)
        cnt <= CW'(CLKS_PER_BIT - 1); // free-running bit clock.
      else
        run <= 1'b0;
    end
  end

endmodule

//--- src/uart_tx_frame.sv
`timescale 1ns/1ps

module uart_tx_frame
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic [7:0] byte_in,
  input  logic       bit_tick,
  output logic       tx,
  output logic       done
);

  logic [FRAME_BITS-1:0] shreg;
  logic                  busy;
  logic [3:0]            bit_cnt;
  logic                  last;

  assign last = (bit_cnt == 4'(FRAME_BITS - 1));
  assign done = busy & bit_tick & last; // the stop bit ends on this tick.

  // ones are shifted in behind the frame, so the line rests high.
  assign tx = shreg[0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shreg   <= '1;
      busy    <= 1'b0;
      bit_cnt <= '0;
    end
    else if (start)
    begin
      // odd parity bit makes the count of ones over data and parity odd.
      shreg   <= {1'b1, ~^byte_in, byte_in, 1'b0};
      busy    <= 1'b1;
      bit_cnt <= '0;
    end
    else if (busy && bit_tick)
    begin
      shreg   <= {1'b1, shreg[FRAME_BITS-1:1]};
      bit_cnt <= bit_cnt + 1'b1;
      if (last)
        busy <= 1'b0;
    end
  end

endmodule

//--- src/uart_rx_frame.sv
`timescale 1ns/1ps

module uart_rx_frame
  import uart_cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       arm,
  input  logic       rx,
  output logic       started,
  output logic       done,
  output logic [7:0] data,
  output logic       parity_err
);

  localparam int CW = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CW-1:0] FULL = CW'(CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] HALF = CW'(CLKS_PER_BIT / 2 - 1);

  logic [2:0]    sync;    // two synchronizer stages and one for edge detection.
  logic          fall;
  logic          busy;
  logic [CW-1:0] cnt;
  logic [3:0]    bit_cnt; // 0 is the start bit, 10 the stop bit.

  assign fall    = sync[2] & ~sync[1];
  assign started = arm & ~busy & fall;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync       <= 3'b111;
      busy       <= 1'b0;
      cnt        <= '0;
      bit_cnt    <= '0;
      done       <= 1'b0;
      data       <= '0;
      parity_err <= 1'b0;
    end
    else
    begin
      sync <= {sync[1:0], rx};
      done <= 1'b0;
      if (started)
      begin
        busy    <= 1'b1;
        cnt     <= HALF; // first sample lands in the middle of the start bit.
        bit_cnt <= '0;
      end
      else if (busy)
      begin
        if (cnt != '0)
        begin
          cnt <= cnt - 1'b1;
        end
        else
        begin
          cnt     <= FULL;
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt inside {[4'd1:4'd8]})
            data <= {sync[1], data[7:1]}; // LSB arrives first.
          else if (bit_cnt == 4'd9)
            parity_err <= ~^{data, sync[1]};
          else if (bit_cnt == 4'(FRAME_BITS - 1))
          begin
            // a low stop bit is reported as a parity error too.
            parity_err <= parity_err | ~sync[1];
            busy       <= 1'b0;
            done       <= 1'b1;
          end
        end
      end
      else if (arm)
      begin
        data       <= '0; // a timed-out read reports zero.
        parity_err <= 1'b0;
      end
    end
  end

endmodule

//--- src/uart_ctrl_fsm.sv
`timescale 1ns/1ps

module uart_ctrl_fsm
  import uart_cmd_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_vld,
  input  logic        cmd_wr,
  output logic        cmd_rdy,
  output logic        tmr_start,
  output timer_mode_e tmr_mode,
  input  logic        tmr_done,
  output logic        tx_start,
  output logic        tx_byte_sel,
  input  logic        tx_done,
  output logic        rx_arm,
  input  logic        rx_started,
  input  logic        rx_done,
  output logic        cmd_latch,
  output logic        resp_vld,
  output logic        resp_timeout
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND_HI,
    ST_GAP,
    ST_SEND_LO,
    ST_AWAIT,
    ST_RECV,
    ST_RESP
  } state_e;

  state_e state;

  assign cmd_latch = cmd_vld & cmd_rdy; // handshake completes on this edge.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= ST_IDLE;
      cmd_rdy      <= 1'b1;
      tmr_start    <= 1'b0;
      tmr_mode     <= TM_BIT;
      tx_start     <= 1'b0;
      tx_byte_sel  <= 1'b0;
      rx_arm       <= 1'b0;
      resp_vld     <= 1'b0;
      resp_timeout <= 1'b0;
    end
    else
    begin
      tmr_start <= 1'b0; // strobes last a single cycle.
      tx_start  <= 1'b0;
      resp_vld  <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (cmd_latch)
          begin
            cmd_rdy      <= 1'b0;
            tx_start     <= 1'b1;
            tx_byte_sel  <= 1'b0; // high byte goes first.
            tmr_start    <= 1'b1;
            tmr_mode     <= TM_BIT;
            resp_timeout <= 1'b0;
            state        <= ST_SEND_HI;
          end
        end
        ST_SEND_HI:
        begin
          if (tx_done)
          begin
            tmr_start <= 1'b1;
            tmr_mode  <= TM_GAP;
            state     <= ST_GAP;
          end
        end
        ST_GAP:
        begin
          if (tmr_done)
          begin
            tx_start    <= 1'b1;
            tx_byte_sel <= 1'b1;
            tmr_start   <= 1'b1;
            tmr_mode    <= TM_BIT;
            state       <= ST_SEND_LO;
          end
        end
        ST_SEND_LO:
        begin
          if (tx_done)
          begin
            if (cmd_wr)
            begin
              cmd_rdy <= 1'b1;
              state   <= ST_IDLE;
            end
            else
            begin
              // the receiver and the reply window open together.
              rx_arm    <= 1'b1;
              tmr_start <= 1'b1;
              tmr_mode  <= TM_WAIT;
              state     <= ST_AWAIT;
            end
          end
        end
        ST_AWAIT:
        begin
          // a start edge in the last cycle of the window still counts.
          if (rx_started)
          begin
            rx_arm <= 1'b0;
            state  <= ST_RECV;
          end
          else if (tmr_done)
          begin
            rx_arm       <= 1'b0;
            resp_timeout <= 1'b1;
            resp_vld     <= 1'b1;
            state        <= ST_RESP;
          end
        end
        ST_RECV:
        begin
          if (rx_done)
          begin
            resp_vld <= 1'b1;
            state    <= ST_RESP;
          end
        end
        ST_RESP:
        begin
          cmd_rdy <= 1'b1;
          state   <= ST_IDLE;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

//--- src/uart_cmd_master.sv
`timescale 1ns/1ps

module uart_cmd_master
  import uart_cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434,
  parameter int GAP_CYCLES   = 100,
  parameter int RESP_TIMEOUT = 4096
) (
  input  logic      clk,
  input  logic      rst_n,
  input  cmd_word_u cmd_in,
  input  logic      cmd_vld,
  output logic      cmd_rdy,
  output logic      tx,
  input  logic      rx,
  output rd_resp_t  resp,
  output logic      resp_vld
);

  cmd_word_u   cmd_q;
  logic        cmd_latch;
  logic        tmr_start;
  timer_mode_e tmr_mode;
  logic        tmr_done;
  logic        bit_tick;
  logic        tx_start;
  logic        tx_byte_sel;
  logic [7:0]  tx_byte;
  logic        tx_done;
  logic        rx_arm;
  logic        rx_started;
  logic        rx_done;
  logic [7:0]  rx_data;
  logic        rx_perr;
  logic        resp_timeout;

  // the command is held here until the next acceptance.
  always_ff @(posedge clk)
  begin
    if (cmd_latch)
      cmd_q <= cmd_in;
  end

  assign tx_byte = tx_byte_sel ? cmd_q.bytes.lo : cmd_q.bytes.hi;
  assign resp    = '{data: rx_data, parity_err: rx_perr, timeout: resp_timeout};

  uart_ctrl_fsm u_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_vld      (cmd_vld),
    .cmd_wr       (cmd_q.fields.wr),
    .cmd_rdy      (cmd_rdy),
    .tmr_start    (tmr_start),
    .tmr_mode     (tmr_mode),
    .tmr_done     (tmr_done),
    .tx_start     (tx_start),
    .tx_byte_sel  (tx_byte_sel),
    .tx_done      (tx_done),
    .rx_arm       (rx_arm),
    .rx_started   (rx_started),
    .rx_done      (rx_done),
    .cmd_latch    (cmd_latch),
    .resp_vld     (resp_vld),
    .resp_timeout (resp_timeout)
  );

  baud_timer #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .GAP_CYCLES   (GAP_CYCLES),
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) u_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (tmr_start),
    .mode     (tmr_mode),
    .bit_tick (bit_tick),
    .done     (tmr_done)
  );

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (tx_start),
    .byte_in  (tx_byte),
    .bit_tick (bit_tick),
    .tx       (tx),
    .done     (tx_done)
  );

  uart_rx_frame #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .arm        (rx_arm),
    .rx         (rx),
    .started    (rx_started),
    .done       (rx_done),
    .data       (rx_data),
    .parity_err (rx_perr)
  );

endmodule

//--- bench/uart_cmd_asserts.sv
`timescale 1ns/1ps

module uart_cmd_asserts (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic resp_vld
);

  // the line idles high whenever the master can take a command.
  a_idle_line: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else $error("tx low while cmd_rdy is high");

  a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n) resp_vld |=> !resp_vld)
    else $error("resp_vld high for more than one cycle");

  a_busy_after_accept: assert property (
    @(posedge clk) disable iff (!rst_n) (cmd_vld && cmd_rdy) |=> !cmd_rdy)
    else $error("cmd_rdy still high after a command was accepted");

endmodule

bind uart_cmd_master uart_cmd_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .resp_vld (resp_vld)
);

//--- bench/tb_uart_cmd_master.sv
`timescale 1ns/1ps

module tb_uart_cmd_master
  import uart_cmd_pkg::*;
();

  localparam int CPB   = 8;
  localparam int GAP   = 20;
  localparam int TMO   = 400;
  localparam int PAUSE = 30; // remote turnaround in clock cycles.
  localparam int NROWS = 8;
  localparam int TAIL  = 200;
  localparam int WORST = 3 * FRAME_BITS * CPB + GAP + TMO + PAUSE + 16;
  localparam int LIMIT = NROWS * WORST + TAIL + 20;

  typedef struct packed {
    logic [15:0] cmd;
    logic [7:0]  reply;
    logic        bad_par; // remote flips its parity bit.
    logic        silent;  // remote never answers.
  } row_t;

  logic        clk;
  logic        rst_n;
  cmd_word_u   cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        tx;
  logic        rx;
  rd_resp_t    resp;
  logic        resp_vld;
  row_t        rows [NROWS];
  logic [31:0] lfsr = 32'd92380;
  int          cyc = 0;
  int          n_resp = 0;

  uart_cmd_master #(
    .CLKS_PER_BIT (CPB),
    .GAP_CYCLES   (GAP),
    .RESP_TIMEOUT (TMO)
  ) UUT (.*);

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (resp_vld)
      n_resp <= n_resp + 1;
    if (cyc >= LIMIT)
    begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // the parity bit tops up an even count of ones.
  function automatic logic odd_parity(input logic [7:0] b);
    int ones;
    int k;
    ones = 0;
    for (k = 0; k < 8; k++)
      if (b[k])
        ones++;
    return (ones % 2) == 0;
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'hD000_0001;
    return s >> 1;
  endfunction

  task automatic draw_byte(output logic [7:0] b);
    int k;
    for (k = 0; k < 8; k++)
    begin
      lfsr = lfsr_next(lfsr);
      b[k] = lfsr[0];
    end
  endtask

  // line monitor. Every sample of a bit has to match, and the decoded bit is the middle one.
  task automatic watch_frame(input logic [7:0] exp_byte, output int start_cyc);
    logic [FRAME_BITS-1:0] bits;
    logic                  level;
    int                    k;
    int                    c;
    do
      @(posedge clk);
    while (tx !== 1'b0);
    start_cyc = cyc;
    for (k = 0; k < FRAME_BITS; k++)
    begin
      for (c = 0; c < CPB; c++)
      begin
        if (k != 0 || c != 0)
          @(posedge clk);
        if (c == 0)
          level = tx;
        if (c == CPB / 2)
          bits[k] = tx;
        check_eq("tx bit length", 32'(tx), 32'(level));
      end
    end
    check_eq("tx data", 32'(bits[8:1]), 32'(exp_byte));
    check_eq("tx parity", 32'(bits[9]), 32'(odd_parity(exp_byte)));
    check_eq("tx stop bit", 32'(bits[10]), 32'd1);
  endtask

  // remote device. It returns at the start of its stop bit.
  task automatic send_reply(input logic [7:0] b, input logic bad_par);
    logic [FRAME_BITS-1:0] bits;
    int                    k;
    bits = {1'b1, odd_parity(b) ^ bad_par, b, 1'b0};
    for (k = 0; k < FRAME_BITS - 1; k++)
    begin
      @(posedge clk);
      rx <= bits[k];
      repeat (CPB - 1) @(posedge clk);
    end
    @(posedge clk);
    rx <= 1'b1;
  endtask

  initial
  begin
    logic [7:0] rnd [4];
    int         i;
    int         k;
    int         acc_cyc;
    int         end_cyc;
    int         hi_start;
    int         lo_start;
    int         n_reads;
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    end_cyc = 0;
    n_reads = 0;
    for (k = 0; k < 4; k++)
      draw_byte(rnd[k]);
    rows = '{
      '{16'h92A5, 8'h00, 1'b0, 1'b0},
      '{16'h0500, 8'h3C, 1'b0, 1'b0},
      '{16'h7F00, 8'h81, 1'b1, 1'b0},  // reply arrives with bad parity.
      '{16'h2100, 8'h00, 1'b0, 1'b1},
      '{{8'hC0, rnd[0]}, 8'h00, 1'b0, 1'b0},
      '{16'h3300, rnd[1], 1'b0, 1'b0},
      '{{8'h8A, rnd[2]}, 8'h00, 1'b0, 1'b0},
      '{16'h6600, rnd[3], 1'b0, 1'b0}
    };
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_eq("cmd_rdy", 32'(cmd_rdy), 32'd1);
    check_eq("tx", 32'(tx), 32'd1);
    check_eq("resp_vld", 32'(resp_vld), 32'd0);
    cmd_in  <= rows[0].cmd;
    cmd_vld <= 1'b1;
    for (i = 0; i < NROWS; i++)
    begin
      do
        @(posedge clk);
      while (!(cmd_vld && cmd_rdy));
      acc_cyc = cyc;
      // cmd_vld stays high, so the next command goes as soon as cmd_rdy returns.
      if (i > 0)
        check_eq("cmd_rdy rise", acc_cyc, end_cyc + 1);
      cmd_in <= ~rows[i].cmd; // a busy master ignores this.
      watch_frame(rows[i].cmd[15:8], hi_start);
      check_eq("first start bit", hi_start, acc_cyc + 2);
      if (i < NROWS - 1)
        cmd_in <= rows[i + 1].cmd;
      else
        cmd_vld <= 1'b0;
      watch_frame(rows[i].cmd[7:0], lo_start);
      check_eq("inter-frame gap", lo_start - hi_start, FRAME_BITS * CPB + GAP);
      if (!rows[i].cmd[15])
      begin
        n_reads++;
        repeat (PAUSE) @(posedge clk);
        if (!rows[i].silent)
          send_reply(rows[i].reply, rows[i].bad_par);
        do
          @(posedge clk);
        while (resp_vld !== 1'b1);
        check_eq("resp.data", 32'(resp.data), rows[i].silent ? 32'd0 : 32'(rows[i].reply));
        check_eq("resp.parity_err", 32'(resp.parity_err), 32'(rows[i].bad_par));
        check_eq("resp.timeout", 32'(resp.timeout), 32'(rows[i].silent));
      end
      end_cyc = cyc;
    end
    for (k = 0; k < TAIL; k++)
    begin
      @(posedge clk);
      check_eq("tx idle", 32'(tx), 32'd1);
      check_eq("cmd_rdy idle", 32'(cmd_rdy), 32'd1);
    end
    check_eq("resp_vld count", n_resp, n_reads);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- sources.f
common/uart_cmd_pkg.sv
src/baud_timer.sv
src/uart_tx_frame.sv
src/uart_rx_frame.sv
src/uart_ctrl_fsm.sv
src/uart_cmd_master.sv
bench/uart_cmd_asserts.sv
bench/tb_uart_cmd_master.sv

//--- run.sh
#!/bin/sh
# Compiles the testbench with Verilator and runs it.
# The exit status follows the pass line in the simulation output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module tb_uart_cmd_master -o tb_sim &&
./obj_dir/tb_sim 2>&1 | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
